//--- vga_pkg.sv
package vga_pkg;

    // red 23:16, green 15:8, blue 7:0
    typedef logic [23:0] pixel_t;

    // register offsets, bus side
    localparam logic [31:0] REG_CTRL        = 32'h0000_0000; // bit 0 display enable
    localparam logic [31:0] REG_BGCOLOR     = 32'h0000_0004;
    localparam logic [31:0] REG_FRAME_COUNT = 32'h0000_0008; // read only

    // paddr[31] selects the frame buffer, word index from bit 2 up
    localparam int FB_SELECT_BIT = 31;

    // 640x480 at 25 MHz
    localparam int H_ACTIVE_DEF = 640;
    localparam int H_FRONT_DEF  = 16;
    localparam int H_SYNC_DEF   = 96;
    localparam int H_BACK_DEF   = 48;

    localparam int V_ACTIVE_DEF = 480;
    localparam int V_FRONT_DEF  = 10;
    localparam int V_SYNC_DEF   = 2;
    localparam int V_BACK_DEF   = 33;

endpackage

//--- vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
    parameter int h_active = vga_pkg::H_ACTIVE_DEF,
    parameter int h_front  = vga_pkg::H_FRONT_DEF,
    parameter int h_sync   = vga_pkg::H_SYNC_DEF,
    parameter int h_back   = vga_pkg::H_BACK_DEF,
    parameter int v_active = vga_pkg::V_ACTIVE_DEF,
    parameter int v_front  = vga_pkg::V_FRONT_DEF,
    parameter int v_sync   = vga_pkg::V_SYNC_DEF,
    parameter int v_back   = vga_pkg::V_BACK_DEF,
    localparam int aw      = $clog2(h_active * v_active)
) (
    input  logic          pclk,
    input  logic          reset,
    output logic          hsync_raw,
    output logic          vsync_raw,
    output logic          active,
    output logic          frame_start,
    output logic [aw-1:0] scan_addr
);

    // line layout: sync, back porch, active, front porch
    localparam int h_total = h_sync + h_back + h_active + h_front;
    localparam int v_total = v_sync + v_back + v_active + v_front;
    localparam int h_start = h_sync + h_back;
    localparam int v_start = v_sync + v_back;
    localparam int hw      = $clog2(h_total);
    localparam int vw      = $clog2(v_total);

    logic [hw-1:0] h_cnt;
    logic [vw-1:0] v_cnt;
    logic          h_act;
    logic          v_act;
    logic          origin;

    assign h_act  = (h_cnt >= h_start) && (h_cnt < h_start + h_active);
    assign v_act  = (v_cnt >= v_start) && (v_cnt < v_start + v_active);
    assign origin = (h_cnt == '0) && (v_cnt == '0);

    always_ff @(posedge pclk or posedge reset) begin
        if (reset) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == hw'(h_total - 1)) begin
            h_cnt <= '0;
            if (v_cnt == vw'(v_total - 1))
                v_cnt <= '0;
            else
                v_cnt <= v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // scan address tracks the counters, memory read supplies the lag
    always_ff @(posedge pclk or posedge reset) begin
        if (reset)
            scan_addr <= '0;
        else if (origin)
            scan_addr <= '0;
        else if (h_act && v_act)
            scan_addr <= scan_addr + 1'b1; // no multiply needed
    end

    always_ff @(posedge pclk or posedge reset) begin
        if (reset) begin
            hsync_raw   <= 1'b1;
            vsync_raw   <= 1'b1;
            active      <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            hsync_raw   <= !(h_cnt < h_sync); // active low
            vsync_raw   <= !(v_cnt < v_sync);
            active      <= h_act && v_act;
            frame_start <= origin;
        end
    end

endmodule

//--- frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer #(
    parameter int  fb_depth = vga_pkg::H_ACTIVE_DEF * vga_pkg::V_ACTIVE_DEF,
    localparam int aw       = $clog2(fb_depth)
) (
    input  logic            pclk,
    input  logic            wr_en,
    input  logic [aw-1:0]   wr_addr,
    input  vga_pkg::pixel_t wr_data,
    input  logic [2:0]      wr_strb,
    input  logic [aw-1:0]   rd_addr,
    output vga_pkg::pixel_t rd_data,
    input  logic [aw-1:0]   scan_addr,
    output vga_pkg::pixel_t scan_data
);

    vga_pkg::pixel_t mem [fb_depth];

    // one byte lane per colour
    always_ff @(posedge pclk) begin
        for (int i = 0; i < 3; i++) begin
            if (wr_en && wr_strb[i])
                mem[wr_addr][i*8 +: 8] <= wr_data[i*8 +: 8];
        end
    end

    always_ff @(posedge pclk) begin
        rd_data <= mem[rd_addr]; // bus side
    end

    always_ff @(posedge pclk) begin
        scan_data <= mem[scan_addr];
    end

endmodule

//--- apb_reg_bank.sv
`timescale 1ns/1ps

module apb_reg_bank #(
    parameter int  fb_depth = vga_pkg::H_ACTIVE_DEF * vga_pkg::V_ACTIVE_DEF,
    localparam int aw       = $clog2(fb_depth)
) (
    input  logic            pclk,
    input  logic            reset,
    input  logic [31:0]     paddr,
    input  logic            psel,
    input  logic            penable,
    input  logic [2:0]      pprot,     // accepted, not decoded
    input  logic            pwrite,
    input  logic [31:0]     pwdata,
    input  logic [3:0]      pstrb,
    output logic            pready,
    output logic [31:0]     prdata,
    output logic            pslverr,
    input  logic            frame_start,
    output logic            display_enable,
    output vga_pkg::pixel_t bg_color,
    output logic            wr_en,
    output logic [aw-1:0]   wr_addr,
    output vga_pkg::pixel_t wr_data,
    output logic [2:0]      wr_strb,
    output logic [aw-1:0]   rd_addr,
    input  vga_pkg::pixel_t rd_data
);

    logic        access;
    logic        fb_sel;
    logic [28:0] fb_index;
    logic        fb_ok;
    logic        hit_ctrl;
    logic        hit_bg;
    logic        hit_cnt;
    logic        err;
    logic        fb_rd;
    logic        rd_pending;
    logic [31:0] frame_count;
    logic [31:0] rdata;

    assign access   = psel && penable;
    assign fb_sel   = paddr[vga_pkg::FB_SELECT_BIT];
    assign fb_index = paddr[30:2];
    assign fb_ok    = fb_index < fb_depth;
    assign hit_ctrl = !fb_sel && (paddr == vga_pkg::REG_CTRL);
    assign hit_bg   = !fb_sel && (paddr == vga_pkg::REG_BGCOLOR);
    assign hit_cnt  = !fb_sel && (paddr == vga_pkg::REG_FRAME_COUNT);

    // count register is read only
    assign err   = fb_sel ? !fb_ok : !(hit_ctrl || hit_bg || (hit_cnt && !pwrite));
    assign fb_rd = fb_sel && fb_ok && !pwrite;

    // one wait state for pixel reads only
    assign pready  = access && (!fb_rd || rd_pending);
    assign pslverr = pready && err;
    assign prdata  = (pready && !err && !pwrite) ? rdata : 32'h0;

    always_comb begin
        if (fb_sel)
            rdata = {8'h00, rd_data};
        else if (hit_ctrl)
            rdata = {31'h0, display_enable};
        else if (hit_bg)
            rdata = {8'h00, bg_color};
        else
            rdata = frame_count;
    end

    assign wr_en   = access && pwrite && fb_sel && fb_ok;
    assign wr_addr = fb_index[aw-1:0];
    assign wr_data = pwdata[23:0];
    assign wr_strb = pstrb[2:0];
    assign rd_addr = fb_index[aw-1:0];

    always_ff @(posedge pclk or posedge reset) begin
        if (reset)
            rd_pending <= 1'b0;
        else
            rd_pending <= access && fb_rd && !rd_pending;
    end

    always_ff @(posedge pclk or posedge reset) begin
        if (reset) begin
            display_enable <= 1'b0;
            bg_color       <= '0;
        end else if (access && pwrite) begin
            if (hit_ctrl && pstrb[0])
                display_enable <= pwdata[0];
            if (hit_bg) begin
                for (int i = 0; i < 3; i++) begin
                    if (pstrb[i])
                        bg_color[i*8 +: 8] <= pwdata[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge pclk or posedge reset) begin
        if (reset)
            frame_count <= '0;
        else if (frame_start)
            frame_count <= frame_count + 1'b1;
    end

endmodule

//--- pixel_pipe.sv
`timescale 1ns/1ps

module pixel_pipe (
    input  logic            pclk,
    input  logic            reset,
    input  logic            hsync_raw,
    input  logic            vsync_raw,
    input  logic            active,
    input  vga_pkg::pixel_t scan_data,
    input  logic            display_enable,
    input  vga_pkg::pixel_t bg_color,
    output logic [7:0]      vga_r,
    output logic [7:0]      vga_g,
    output logic [7:0]      vga_b,
    output logic            vga_hsync,
    output logic            vga_vsync,
    output logic            vga_valid
);

    vga_pkg::pixel_t pix;

    always_comb begin
        if (!active)
            pix = '0; // blanking is black
        else if (display_enable)
            pix = scan_data;
        else
            pix = bg_color;
    end

    // second stage after the timing register, lines up with scan_data
    always_ff @(posedge pclk or posedge reset) begin
        if (reset) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_valid <= 1'b0;
            {vga_r, vga_g, vga_b} <= '0;
        end else begin
            vga_hsync <= hsync_raw;
            vga_vsync <= vsync_raw;
            vga_valid <= active;
            {vga_r, vga_g, vga_b} <= pix;
        end
    end

endmodule

//--- vga_top_apb.sv
`timescale 1ns/1ps

module vga_top_apb #(
    parameter int h_active = vga_pkg::H_ACTIVE_DEF,
    parameter int h_front  = vga_pkg::H_FRONT_DEF,
    parameter int h_sync   = vga_pkg::H_SYNC_DEF,
    parameter int h_back   = vga_pkg::H_BACK_DEF,
    parameter int v_active = vga_pkg::V_ACTIVE_DEF,
    parameter int v_front  = vga_pkg::V_FRONT_DEF,
    parameter int v_sync   = vga_pkg::V_SYNC_DEF,
    parameter int v_back   = vga_pkg::V_BACK_DEF
) (
    input  logic        pclk,
    input  logic        reset,
    input  logic [31:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic [2:0]  pprot,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    input  logic [3:0]  pstrb,
    output logic        pready,
    output logic [31:0] prdata,
    output logic        pslverr,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b,
    output logic        vga_hsync,
    output logic        vga_vsync,
    output logic        vga_valid
);

    localparam int fb_depth = h_active * v_active;
    localparam int aw       = $clog2(fb_depth);

    logic            hsync_raw;
    logic            vsync_raw;
    logic            active;
    logic            frame_start;
    logic [aw-1:0]   scan_addr;
    vga_pkg::pixel_t scan_data;
    logic            display_enable;
    vga_pkg::pixel_t bg_color;
    logic            wr_en;
    logic [aw-1:0]   wr_addr;
    vga_pkg::pixel_t wr_data;
    logic [2:0]      wr_strb;
    logic [aw-1:0]   rd_addr;
    vga_pkg::pixel_t rd_data;

    vga_timing #(
        .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
    ) u_timing (
        .pclk(pclk), .reset(reset),
        .hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .active(active),
        .frame_start(frame_start), .scan_addr(scan_addr)
    );

    frame_buffer #(.fb_depth(fb_depth)) u_fb (
        .pclk(pclk),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb),
        .rd_addr(rd_addr), .rd_data(rd_data),
        .scan_addr(scan_addr), .scan_data(scan_data)
    );

    apb_reg_bank #(.fb_depth(fb_depth)) u_regs (
        .pclk(pclk), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pprot(pprot),
        .pwrite(pwrite), .pwdata(pwdata), .pstrb(pstrb),
        .pready(pready), .prdata(prdata), .pslverr(pslverr),
        .frame_start(frame_start),
        .display_enable(display_enable), .bg_color(bg_color),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .wr_strb(wr_strb),
        .rd_addr(rd_addr), .rd_data(rd_data)
    );

    pixel_pipe u_pipe (
        .pclk(pclk), .reset(reset),
        .hsync_raw(hsync_raw), .vsync_raw(vsync_raw), .active(active),
        .scan_data(scan_data), .display_enable(display_enable), .bg_color(bg_color),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
        .vga_hsync(vga_hsync), .vga_vsync(vga_vsync), .vga_valid(vga_valid)
    );

endmodule

//--- tb_vga_top_apb.sv
`timescale 1ns/1ps

module tb_vga_top_apb;

    logic pclk, reset, psel, penable, pwrite, pready, pslverr;
    logic vga_hsync, vga_vsync, vga_valid;
    logic [31:0] paddr, pwdata, prdata, rd_val, cnt_a, cnt_b;
    logic [3:0] pstrb;
    logic [2:0] pprot, strb3;
    logic [7:0] vga_r, vga_g, vga_b;
    logic [31:0] rng = 32'h5410;
    vga_pkg::pixel_t model [32];
    vga_pkg::pixel_t bg_model, expect_pix;
    logic en_model, check_en, err_bit, prev_h, prev_vs, prev_valid;
    int errors, tests_run, waits, cycles, h_low, vs_low, v_run, line_runs;
    int vs_falls, pix_idx, pix_checked, mark;

    vga_top_apb #(.h_active(8), .h_front(2), .h_sync(3), .h_back(2),
                  .v_active(4), .v_front(1), .v_sync(2), .v_back(1)) uut (.*);

    always #5 pclk = !pclk;

    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic confirm(logic cond, string what);
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    // sample comb outputs mid low phase, before the completing edge
    task automatic apb_xfer(logic [31:0] addr, logic wr, logic [31:0] data, logic [3:0] strb);
        @(negedge pclk);
        paddr = addr;
        pwrite = wr;
        pwdata = data;
        pstrb = strb;
        psel = 1'b1;
        @(negedge pclk);
        penable = 1'b1;
        waits = 0;
        #2;
        while (!pready) begin
            waits++;
            @(negedge pclk);
            #2;
        end
        rd_val = prdata;
        err_bit = pslverr;
        @(posedge pclk);
        @(negedge pclk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic wait_frames(int n);
        int target;
        target = vs_falls + n;
        while (vs_falls < target) @(negedge pclk);
    endtask

    task automatic report(string name);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - mark);
        mark = errors;
    endtask

    // raster and pixel monitor, sees pre-edge values
    always @(posedge pclk) begin
        cycles++;
        if (cycles >= 6000) begin
            $display("Timeout: run passed the cycle limit of 6000");
            $display("Simulation FAILED");
            $finish;
        end else if (!reset) begin
            if (!vga_hsync)
                h_low++;
            else if (!prev_h) begin
                check_val("hsync low cycles", h_low, 3);
                h_low = 0;
            end
            if (vga_valid)
                v_run++;
            else if (prev_valid) begin
                check_val("valid run", v_run, 8);
                v_run = 0;
                line_runs++;
            end
            if (!vga_vsync)
                vs_low++;
            if (prev_vs && !vga_vsync) begin
                vs_falls++;
                if (vs_falls > 1)
                    check_val("valid lines", line_runs, 4);
                line_runs = 0;
            end
            if (!prev_vs && vga_vsync) begin
                check_val("vsync low cycles", vs_low, 30);
                vs_low = 0;
                pix_idx = 0;
            end
            if (vga_valid) begin
                expect_pix = en_model ? model[pix_idx % 32] : bg_model;
                if (check_en) begin
                    check_val("vga_rgb", {8'h0, vga_r, vga_g, vga_b}, {8'h0, expect_pix});
                    pix_checked++;
                end
                pix_idx++;
            end
            prev_h = vga_hsync;
            prev_vs = vga_vsync;
            prev_valid = vga_valid;
        end
    end

    blank_black: assert property (@(posedge pclk) disable iff (reset)
        !vga_valid |-> {vga_r, vga_g, vga_b} == 24'h0)
        else begin
            $display("Fail %0t vga_rgb got %h expected 000000 while valid low", $time,
                     $sampled({vga_r, vga_g, vga_b}));
            errors++;
        end

    initial begin
        pclk = 0;
        reset = 1;
        psel = 0;
        penable = 0;
        pwrite = 0;
        pprot = 3'b0;
        paddr = 0;
        pwdata = 0;
        pstrb = 0;
        check_en = 0;
        en_model = 0;
        bg_model = 0;
        prev_h = 1;
        prev_vs = 1;
        prev_valid = 0;
        repeat (16) @(negedge pclk);
        check_val("vga_hsync", 32'(vga_hsync), 1);
        check_val("vga_vsync", 32'(vga_vsync), 1);
        check_val("vga_valid", 32'(vga_valid), 0);
        check_val("vga_rgb", {8'h0, vga_r, vga_g, vga_b}, 0);
        check_val("pready", 32'(pready), 0);
        check_val("pslverr", 32'(pslverr), 0);
        check_val("prdata", prdata, 0);
        reset = 0;
        apb_xfer(vga_pkg::REG_CTRL, 0, 0, 0);
        check_val("ctrl", rd_val, 0);
        apb_xfer(vga_pkg::REG_BGCOLOR, 0, 0, 0);
        check_val("bgcolor", rd_val, 0);
        report("reset state");

        apb_xfer(vga_pkg::REG_CTRL, 1, 32'hffff_ffff, 4'b0001);
        apb_xfer(vga_pkg::REG_CTRL, 1, 0, 4'b0000); // masked, keeps bit
        apb_xfer(vga_pkg::REG_CTRL, 0, 0, 0);
        check_val("ctrl", rd_val, 1);
        check_val("ctrl read waits", waits, 0);
        apb_xfer(vga_pkg::REG_BGCOLOR, 1, 32'h12ab_cdef, 4'b0101);
        bg_model = 24'hab00ef;
        apb_xfer(vga_pkg::REG_BGCOLOR, 0, 0, 0);
        check_val("bgcolor", rd_val, {8'h0, bg_model});
        apb_xfer(32'h0000_000c, 0, 0, 0);
        check_val("pslverr unmapped read", 32'(err_bit), 1);
        apb_xfer(32'h0000_0010, 1, 5, 4'hf);
        check_val("pslverr unmapped write", 32'(err_bit), 1);
        while (!vga_valid) @(negedge pclk); // well clear of the next frame start
        apb_xfer(vga_pkg::REG_FRAME_COUNT, 0, 0, 0);
        cnt_a = rd_val;
        apb_xfer(vga_pkg::REG_FRAME_COUNT, 1, 0, 4'hf);
        check_val("pslverr count write", 32'(err_bit), 1);
        apb_xfer(vga_pkg::REG_FRAME_COUNT, 0, 0, 0);
        cnt_b = rd_val;
        check_val("frame_count before write", cnt_a, vs_falls);
        check_val("frame_count after write", cnt_b, vs_falls);
        apb_xfer(32'h8000_0080, 0, 0, 0);
        check_val("pslverr fb read 32", 32'(err_bit), 1);
        apb_xfer(32'h8000_0100, 1, 1, 4'hf);
        check_val("pslverr fb write 64", 32'(err_bit), 1);
        apb_xfer(32'h8000_0000, 0, 0, 0);
        check_val("fb read waits", waits, 1);
        apb_xfer(vga_pkg::REG_CTRL, 1, 0, 4'b0001);
        report("registers and errors");

        for (int i = 0; i < 32; i++) begin
            model[i] = 24'(lcg_next());
            apb_xfer(32'h8000_0000 | (i << 2), 1, {8'h0, model[i]}, 4'hf);
        end
        for (int i = 0; i < 32; i++) begin
            pwdata = lcg_next();
            strb3 = pwdata[26:24];
            for (int b = 0; b < 3; b++)
                if (strb3[b]) model[i][b*8 +: 8] = pwdata[b*8 +: 8];
            apb_xfer(32'h8000_0000 | (i << 2), 1, pwdata, {1'b0, strb3});
        end
        for (int i = 0; i < 32; i++) begin
            apb_xfer(32'h8000_0000 | (i << 2), 0, 0, 0);
            check_val("fb prdata", rd_val, {8'h0, model[i]});
            check_val("fb pslverr", 32'(err_bit), 0);
            check_val("fb read waits", waits, 1);
        end
        report("frame buffer");

        wait_frames(3);
        report("raster timing");

        apb_xfer(vga_pkg::REG_CTRL, 1, 1, 4'b0001);
        en_model = 1;
        while (vga_vsync) @(negedge pclk);
        check_en = 1;
        wait_frames(2);
        check_en = 0;
        apb_xfer(vga_pkg::REG_CTRL, 1, 0, 4'b0001);
        en_model = 0;
        wait_frames(1);
        check_en = 1;
        wait_frames(2);
        check_en = 0;
        confirm(pix_checked >= 96, "too few valid pixels were checked");
        report("pixel content");

        while (!vga_valid) @(negedge pclk);
        apb_xfer(vga_pkg::REG_FRAME_COUNT, 0, 0, 0);
        check_val("frame_count", rd_val, vs_falls);
        report("frame counter");

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- vlog.f
vga_pkg.sv
vga_timing.sv
frame_buffer.sv
apb_reg_bank.sv
pixel_pipe.sv
vga_top_apb.sv
tb_vga_top_apb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_vga_top_apb -o sim_vga \
    || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/sim_vga)
echo "$sim_out"
echo "$sim_out" | grep -q "Simulation PASSED" && exit 0 || exit 1
